// File: hdl/dcache_config.svh
/* Size parameters of the data cache: word, address, set count and
   write-buffer depth. */

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Width of one data word in bits.
`define DC_WORD_W 32

// One byte select per byte of the word.
`define DC_SEL_W (`DC_WORD_W / 8)

// Width of a word address.
`define DC_ADDR_W 16

// Number of sets in the direct-mapped array.
`define DC_SETS 16

// Index bits, which must match the set count above.
`define DC_INDEX_W 4

// The tag is whatever the index leaves of the word address.
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W)

// Entries in the write buffer toward memory.
// The depth is a power of two, so the buffer pointers wrap on their own.
`define DC_WBUF_DEPTH 4

`endif

// File: hdl/dcache_pkg.sv
/* Shared types of the data cache: operation and sequencer enums,
   the memory request struct and the lookup result struct. */

`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

	// Operation code carried on both memory ports.
	typedef enum logic [1:0] {
		PI_NOP = 2'b00,
		PI_WR  = 2'b01,
		PI_RD  = 2'b10
	} pi_op_e;

	// State of the memory-port sequencer.
	typedef enum logic [1:0] {
		PORT_IDLE  = 2'b00,
		PORT_WRITE = 2'b01,
		PORT_READ  = 2'b10
	} port_state_e;

	// One memory request.
	// The same layout is used on the processor side and toward memory.
	typedef struct packed {
		pi_op_e                 op;
		logic [`DC_ADDR_W-1:0]  addr;
		logic [`DC_WORD_W-1:0]  data;
		logic [`DC_SEL_W-1:0]   sel;
	} mem_req_t;

	// Result of a lookup, valid one cycle after the index was presented.
	// The sweeping flag is live and does not depend on a lookup.
	typedef struct packed {
		logic                   hit;
		logic [`DC_WORD_W-1:0]  word;
		logic                   sweeping;
	} lookup_t;

endpackage

`default_nettype wire

// File: hdl/dcache_store.sv
/* Tag, data and valid arrays of the direct-mapped cache, with the
   post-reset invalidation sweep and the registered lookup. */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_store (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire                     cenable_i,
	input  wire [`DC_INDEX_W-1:0]   rd_index_i,
	input  wire                     rd_en_i,
	input  wire                     wr_en_i,
	input  wire [`DC_ADDR_W-1:0]    wr_addr_i,
	input  wire [`DC_WORD_W-1:0]    wr_word_i,
	output dcache_pkg::lookup_t     lookup_o
);

	logic [`DC_TAG_W-1:0]   tag_mem  [`DC_SETS];
	logic [`DC_WORD_W-1:0]  data_mem [`DC_SETS];
	logic [`DC_SETS-1:0]    valid_q;

	logic                   sweep_q;
	logic [`DC_INDEX_W-1:0] sweep_idx_q;

	logic [`DC_TAG_W-1:0]   rd_tag_q;
	logic [`DC_WORD_W-1:0]  rd_word_q;
	logic                   rd_valid_q;
	logic                   rd_cen_q;

	logic [`DC_INDEX_W-1:0] wr_index;
	logic [`DC_TAG_W-1:0]   wr_tag;

	// The write address is also the address the controller is resolving,
	// so its tag is the one compared against the stored tag.
	assign wr_index = wr_addr_i[`DC_INDEX_W-1:0];
	assign wr_tag   = wr_addr_i[`DC_ADDR_W-1:`DC_INDEX_W];

	// Sweep counter.
	// It walks every set once after reset, one set per cycle.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sweep_q     <= 1'b1;
			sweep_idx_q <= '0;
		end else if (sweep_q) begin
			sweep_idx_q <= sweep_idx_q + 1'b1;
			if (sweep_idx_q == `DC_INDEX_W'(`DC_SETS - 1)) begin
				sweep_q <= 1'b0;
			end
		end
	end

	// Valid bits are cleared by the sweep and set by a store write.
	always_ff @(posedge clk_i) begin
		if (sweep_q) begin
			valid_q[sweep_idx_q] <= 1'b0;
		end else if (wr_en_i) begin
			valid_q[wr_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en_i) begin
			tag_mem[wr_index]  <= wr_tag;
			data_mem[wr_index] <= wr_word_i;
		end
	end

	// Registered read port.
	// A write to the same set at the same edge is not seen here; the
	// controller covers that case.
	always_ff @(posedge clk_i) begin
		if (rd_en_i) begin
			rd_tag_q  <= tag_mem[rd_index_i];
			rd_word_q <= data_mem[rd_index_i];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_valid_q <= 1'b0;
			rd_cen_q   <= 1'b0;
		end else if (rd_en_i) begin
			rd_valid_q <= valid_q[rd_index_i];
			rd_cen_q   <= cenable_i;
		end
	end

	// Caching is judged on the enable seen when the lookup was started.
	assign lookup_o.hit      = rd_valid_q && rd_cen_q && (rd_tag_q == wr_tag);
	assign lookup_o.word     = rd_word_q;
	assign lookup_o.sweeping = sweep_q;

endmodule

`default_nettype wire

// File: hdl/dcache_mem_port.sv
/* Write buffer toward memory and the sequencer that drains it and
   issues read fetches on the memory port. */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_mem_port #(
	parameter int LVL_W = $clog2(`DC_WBUF_DEPTH + 1)
) (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire                     push_i,
	input  wire dcache_pkg::mem_req_t push_req_i,
	input  wire                     fetch_i,
	input  wire [`DC_ADDR_W-1:0]    fetch_addr_i,
	output logic [LVL_W-1:0]        level_o,
	output logic                    fetch_done_o,
	output logic [`DC_WORD_W-1:0]   fetch_word_o,
	output dcache_pkg::mem_req_t    s_req_o,
	input  wire [`DC_WORD_W-1:0]    s_data_i,
	input  wire                     s_rdy_i
);

	localparam int PTR_W = $clog2(`DC_WBUF_DEPTH);

	dcache_pkg::mem_req_t       buf_q [`DC_WBUF_DEPTH];
	logic [PTR_W-1:0]           wr_ptr_q;
	logic [PTR_W-1:0]           rd_ptr_q;
	logic [LVL_W-1:0]           level_q;

	dcache_pkg::port_state_e    state_q;
	dcache_pkg::port_state_e    state_d;
	logic                       fetch_pend_q;

	logic                       issue_wr;
	logic                       issue_rd;

	// A write goes out whenever the memory is ready and the buffer is
	// not empty. A fetch waits until every buffered write has gone out.
	assign issue_wr = s_rdy_i && (level_q != '0) && (state_q != dcache_pkg::PORT_READ);
	assign issue_rd = s_rdy_i && (level_q == '0) && fetch_pend_q &&
		(state_q != dcache_pkg::PORT_READ);

	// The buffer head falls through to the memory port.
	always_ff @(posedge clk_i) begin
		if (push_i) begin
			buf_q[wr_ptr_q] <= push_req_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (issue_wr) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push_i, issue_wr})
				2'b10:   level_q <= level_q + 1'b1;
				2'b01:   level_q <= level_q - 1'b1;
				default: level_q <= level_q;
			endcase
		end
	end

	// Sequencer.
	// A write needs no answer, so the next one may go out in the cycle
	// that completes it. A read stays in PORT_READ until its word arrives.
	always_comb begin
		state_d = state_q;
		case (state_q)
			dcache_pkg::PORT_READ: begin
				if (s_rdy_i) begin
					state_d = dcache_pkg::PORT_IDLE;
				end
			end
			default: begin
				if (issue_wr) begin
					state_d = dcache_pkg::PORT_WRITE;
				end else if (issue_rd) begin
					state_d = dcache_pkg::PORT_READ;
				end else if (s_rdy_i) begin
					state_d = dcache_pkg::PORT_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q      <= dcache_pkg::PORT_IDLE;
			fetch_pend_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (issue_rd) begin
				fetch_pend_q <= 1'b0;
			end else if (fetch_i) begin
				fetch_pend_q <= 1'b1;
			end
		end
	end

	// The fetch address is held by the controller until the fetch is done.
	always_comb begin
		s_req_o    = buf_q[rd_ptr_q];
		s_req_o.op = dcache_pkg::PI_NOP;
		if (issue_wr) begin
			s_req_o.op = dcache_pkg::PI_WR;
		end else if (issue_rd) begin
			s_req_o.op   = dcache_pkg::PI_RD;
			s_req_o.addr = fetch_addr_i;
			s_req_o.data = '0;
			s_req_o.sel  = '1;
		end
	end

	assign level_o      = level_q;
	assign fetch_done_o = (state_q == dcache_pkg::PORT_READ) && s_rdy_i;
	assign fetch_word_o = s_data_i;

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl.sv
/* Cache controller: holds the accepted request, resolves hit or miss,
   drives the processor side and orders fills and write merges. */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl #(
	parameter int LVL_W = $clog2(`DC_WBUF_DEPTH + 1)
) (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire dcache_pkg::mem_req_t m_req_i,
	input  wire                     cenable_i,
	output logic [`DC_WORD_W-1:0]   m_data_o,
	output logic                    m_rdy_o,
	output logic [`DC_INDEX_W-1:0]  rd_index_o,
	output logic                    rd_en_o,
	output logic                    wr_en_o,
	output logic [`DC_ADDR_W-1:0]   wr_addr_o,
	output logic [`DC_WORD_W-1:0]   wr_word_o,
	input  wire dcache_pkg::lookup_t lookup_i,
	output logic                    push_o,
	output dcache_pkg::mem_req_t    push_req_o,
	output logic                    fetch_o,
	output logic [`DC_ADDR_W-1:0]   fetch_addr_o,
	input  wire [LVL_W-1:0]         level_i,
	input  wire                     fetch_done_i,
	input  wire [`DC_WORD_W-1:0]    fetch_word_i
);

	dcache_pkg::mem_req_t   req_q;
	logic                   look_q;
	logic                   stall_q;
	logic                   miss_q;
	logic                   fill_src_q;
	logic [`DC_WORD_W-1:0]  fill_word_q;
	logic                   last_wr_q;
	logic [`DC_INDEX_W-1:0] last_idx_q;
	logic [`DC_WORD_W-1:0]  last_word_q;

	logic [`DC_INDEX_W-1:0] req_idx;
	logic                   accept;
	logic                   same_set;
	logic                   miss_now;
	logic                   fill;
	logic [`DC_WORD_W-1:0]  base_word;
	logic [`DC_WORD_W-1:0]  merged;

	assign req_idx = req_q.addr[`DC_INDEX_W-1:0];

	// look_q marks the cycle in which lookup_i belongs to req_q.
	assign miss_now = look_q && (req_q.op == dcache_pkg::PI_RD) && !lookup_i.hit;
	assign fill     = miss_q && fetch_done_i;

	// Not ready while sweeping, stalling, missing, or when one more write
	// could overrun the buffer.
	assign m_rdy_o = !lookup_i.sweeping && !stall_q && !miss_q && !miss_now &&
		(level_i < LVL_W'(`DC_WBUF_DEPTH - 1));

	assign accept = m_rdy_o && (m_req_i.op != dcache_pkg::PI_NOP);

	// A read right behind a write to its set would see the word from
	// before the merge, so it is looked up a second time.
	assign same_set = (m_req_i.op == dcache_pkg::PI_RD) && look_q &&
		(req_q.op == dcache_pkg::PI_WR) && (m_req_i.addr[`DC_INDEX_W-1:0] == req_idx);

	// Back-to-back writes to one set take the previous merge as their base.
	assign base_word = (look_q && last_wr_q && (last_idx_q == req_idx)) ?
		last_word_q : lookup_i.word;

	always_comb begin
		for (int b = 0; b < `DC_SEL_W; b++) begin
			merged[b*8 +: 8] = req_q.sel[b] ? req_q.data[b*8 +: 8] : base_word[b*8 +: 8];
		end
	end

	assign rd_en_o    = accept || stall_q;
	assign rd_index_o = stall_q ? req_idx : m_req_i.addr[`DC_INDEX_W-1:0];

	// Write misses do not allocate. A fill is skipped while caching is off.
	assign wr_en_o   = (look_q && (req_q.op == dcache_pkg::PI_WR) && lookup_i.hit) ||
		(fill && cenable_i);
	assign wr_addr_o = req_q.addr;
	assign wr_word_o = miss_q ? fetch_word_i : merged;

	// Every write goes through to memory from the cycle it is accepted.
	assign push_o       = accept && (m_req_i.op == dcache_pkg::PI_WR);
	assign push_req_o   = m_req_i;
	assign fetch_o      = miss_now;
	assign fetch_addr_o = req_q.addr;

	assign m_data_o = fill_src_q ? fill_word_q : lookup_i.word;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			look_q     <= 1'b0;
			stall_q    <= 1'b0;
			miss_q     <= 1'b0;
			fill_src_q <= 1'b0;
			last_wr_q  <= 1'b0;
		end else begin
			look_q    <= (accept && !same_set) || stall_q;
			stall_q   <= accept && same_set;
			last_wr_q <= wr_en_o;
			if (miss_now) begin
				miss_q <= 1'b1;
			end else if (fetch_done_i) begin
				miss_q <= 1'b0;
			end
			if (accept) begin
				fill_src_q <= 1'b0;
			end else if (fill) begin
				fill_src_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			req_q <= m_req_i;
		end
		if (fill) begin
			fill_word_q <= fetch_word_i;
		end
		last_idx_q  <= req_idx;
		last_word_q <= wr_word_o;
	end

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
/* Top of the write-through data cache: store, memory port and controller. */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire                     cenable_i,
	input  wire dcache_pkg::mem_req_t m_req_i,
	output logic [`DC_WORD_W-1:0]   m_data_o,
	output logic                    m_rdy_o,
	output dcache_pkg::mem_req_t    s_req_o,
	input  wire [`DC_WORD_W-1:0]    s_data_i,
	input  wire                     s_rdy_i
);

	localparam int LVL_W = $clog2(`DC_WBUF_DEPTH + 1);

	logic [`DC_INDEX_W-1:0] rd_index;
	logic                   rd_en;
	logic                   wr_en;
	logic [`DC_ADDR_W-1:0]  wr_addr;
	logic [`DC_WORD_W-1:0]  wr_word;
	dcache_pkg::lookup_t    lookup;
	logic                   push;
	dcache_pkg::mem_req_t   push_req;
	logic                   fetch;
	logic [`DC_ADDR_W-1:0]  fetch_addr;
	logic [LVL_W-1:0]       level;
	logic                   fetch_done;
	logic [`DC_WORD_W-1:0]  fetch_word;

	dcache_store u_store (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cenable_i  (cenable_i),
		.rd_index_i (rd_index),
		.rd_en_i    (rd_en),
		.wr_en_i    (wr_en),
		.wr_addr_i  (wr_addr),
		.wr_word_i  (wr_word),
		.lookup_o   (lookup)
	);

	dcache_mem_port #(
		.LVL_W (LVL_W)
	) u_port (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.push_i       (push),
		.push_req_i   (push_req),
		.fetch_i      (fetch),
		.fetch_addr_i (fetch_addr),
		.level_o      (level),
		.fetch_done_o (fetch_done),
		.fetch_word_o (fetch_word),
		.s_req_o      (s_req_o),
		.s_data_i     (s_data_i),
		.s_rdy_i      (s_rdy_i)
	);

	dcache_ctrl #(
		.LVL_W (LVL_W)
	) u_ctrl (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.m_req_i      (m_req_i),
		.cenable_i    (cenable_i),
		.m_data_o     (m_data_o),
		.m_rdy_o      (m_rdy_o),
		.rd_index_o   (rd_index),
		.rd_en_o      (rd_en),
		.wr_en_o      (wr_en),
		.wr_addr_o    (wr_addr),
		.wr_word_o    (wr_word),
		.lookup_i     (lookup),
		.push_o       (push),
		.push_req_o   (push_req),
		.fetch_o      (fetch),
		.fetch_addr_o (fetch_addr),
		.level_i      (level),
		.fetch_done_i (fetch_done),
		.fetch_word_i (fetch_word)
	);

endmodule

`default_nettype wire

// File: verif/mem_model.sv
/* Word memory behind the cache, with a random busy time after each
   request and a count of the writes it has taken. */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module mem_model (
	input  wire                       clk_i,
	input  wire                       rst_i,
	input  wire                       slow_i,
	input  wire dcache_pkg::mem_req_t req_i,
	output logic [`DC_WORD_W-1:0]     data_o,
	output logic                      rdy_o,
	output int                        wr_count_o
);

	logic [`DC_WORD_W-1:0] mem [2**`DC_ADDR_W];
	integer                seed;
	int                    wait_q;
	int                    lat;

	// Every word starts with a value built from its whole address.
	initial begin
		seed = 32'h93e6;
		for (int a = 0; a < 2**`DC_ADDR_W; a++) begin
			mem[a] = {`DC_ADDR_W'(a) ^ 16'h3c5a, ~`DC_ADDR_W'(a) + 16'h0101};
		end
	end

	// A request is taken only while ready; ready then stays low for 0 to 3 cycles.
	// The slow input holds every request at the longest busy time.
	always @(posedge clk_i) begin
		if (rst_i) begin
			rdy_o      <= 1'b1;
			wait_q     <= 0;
			data_o     <= '0;
			wr_count_o <= 0;
		end else if (!rdy_o) begin
			if (wait_q <= 1) begin
				rdy_o <= 1'b1;
			end
			wait_q <= wait_q - 1;
		end else if (req_i.op != dcache_pkg::PI_NOP) begin
			lat = slow_i ? 3 : int'($unsigned($random(seed)) % 4);
			if (req_i.op == dcache_pkg::PI_WR) begin
				for (int b = 0; b < `DC_SEL_W; b++) begin
					if (req_i.sel[b]) begin
						mem[req_i.addr][b*8 +: 8] <= req_i.data[b*8 +: 8];
					end
				end
				wr_count_o <= wr_count_o + 1;
			end else begin
				data_o <= mem[req_i.addr];
			end
			if (lat != 0) begin
				rdy_o  <= 1'b0;
				wait_q <= lat;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/dcache_tb.sv
/* Testbench for the data cache: clock, reset, directed tests against a
   shadow memory, value checker, cycle limit and summary. */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;

	localparam int CYCLE_LIMIT = 4000;

	logic                   clk;
	logic                   rst;
	logic                   cenable;
	logic                   slow;
	dcache_pkg::mem_req_t   m_req;
	logic [`DC_WORD_W-1:0]  m_data;
	logic                   m_rdy;
	dcache_pkg::mem_req_t   s_req;
	logic [`DC_WORD_W-1:0]  s_data;
	logic                   s_rdy;
	int                     wr_count;

	logic [`DC_WORD_W-1:0]  shadow [2**`DC_ADDR_W];
	integer                 seed;
	int                     checks;
	int                     errors;
	int                     writes_sent;
	int                     cycles = 0;

	dcache_top u_dut (
		.clk_i     (clk),
		.rst_i     (rst),
		.cenable_i (cenable),
		.m_req_i   (m_req),
		.m_data_o  (m_data),
		.m_rdy_o   (m_rdy),
		.s_req_o   (s_req),
		.s_data_i  (s_data),
		.s_rdy_i   (s_rdy)
	);

	mem_model u_mem (
		.clk_i      (clk),
		.rst_i      (rst),
		.slow_i     (slow),
		.req_i      (s_req),
		.data_o     (s_data),
		.rdy_o      (s_rdy),
		.wr_count_o (wr_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Contents of the memory model before the first write.
	function automatic logic [`DC_WORD_W-1:0] initial_word(input logic [`DC_ADDR_W-1:0] addr);
		return {addr ^ 16'h3c5a, ~addr + 16'h0101};
	endfunction

	function automatic logic [`DC_WORD_W-1:0] merge_bytes(input logic [`DC_WORD_W-1:0] old,
		input logic [`DC_WORD_W-1:0] data, input logic [`DC_SEL_W-1:0] sel);
		logic [`DC_WORD_W-1:0] w;
		w = old;
		for (int b = 0; b < `DC_SEL_W; b++) begin
			if (sel[b]) begin
				w[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return w;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// Entered at a falling edge; holds the request until the cache takes it.
	task automatic issue(input dcache_pkg::mem_req_t req);
		while (m_rdy !== 1'b1) begin
			@(negedge clk);
		end
		m_req = req;
		@(negedge clk);
		m_req.op = dcache_pkg::PI_NOP;
	endtask

	task automatic read_word(input logic [`DC_ADDR_W-1:0] addr,
		output logic [`DC_WORD_W-1:0] data, output int low_cycles);
		dcache_pkg::mem_req_t req;
		req      = '0;
		req.op   = dcache_pkg::PI_RD;
		req.addr = addr;
		req.sel  = '1;
		issue(req);
		low_cycles = 0;
		while (m_rdy !== 1'b1) begin
			low_cycles++;
			@(negedge clk);
		end
		data = m_data;
	endtask

	task automatic read_check(input string name, input logic [`DC_ADDR_W-1:0] addr);
		logic [`DC_WORD_W-1:0] data;
		int                    low;
		read_word(addr, data, low);
		check_eq(name, shadow[addr], data);
	endtask

	task automatic write_word(input logic [`DC_ADDR_W-1:0] addr,
		input logic [`DC_WORD_W-1:0] data, input logic [`DC_SEL_W-1:0] sel);
		dcache_pkg::mem_req_t req;
		req.op   = dcache_pkg::PI_WR;
		req.addr = addr;
		req.data = data;
		req.sel  = sel;
		issue(req);
		shadow[addr] = merge_bytes(shadow[addr], data, sel);
		writes_sent++;
	endtask

	task automatic wait_drained();
		while (wr_count != writes_sent) begin
			@(negedge clk);
		end
	endtask

	task automatic reset_sweep();
		int low;
		low = 0;
		while (m_rdy !== 1'b1 && low <= `DC_SETS + 2) begin
			low++;
			@(negedge clk);
		end
		if (low > `DC_SETS + 2) begin
			$display("reset: m_rdy_o stayed low for more than %0d cycles", `DC_SETS + 2);
			errors++;
		end
		for (int i = 0; i < `DC_SETS; i++) begin
			read_check("reset", 16'h0100 + 16'(i));
		end
	endtask

	// The second read must hit, so ready may not drop after it is taken.
	task automatic fill_then_hit(input logic [`DC_ADDR_W-1:0] addr);
		logic [`DC_WORD_W-1:0] data;
		int                    low;
		read_word(addr, data, low);
		check_eq("fill", shadow[addr], data);
		read_word(addr, data, low);
		check_eq("hit", shadow[addr], data);
		check_eq("hit ready", 32'(0), 32'(low));
	endtask

	task automatic write_merge();
		read_check("merge", 16'h0104);
		write_word(16'h0104, 32'ha1b2c3d4, 4'b0001);
		read_check("merge", 16'h0104);
		write_word(16'h0104, 32'h11223344, 4'b0110);
		read_check("merge", 16'h0104);
		write_word(16'h0104, 32'h55667788, 4'b1000);
		read_check("merge", 16'h0104);
		write_word(16'h0104, 32'hdeadbeef, 4'b0011);
		write_word(16'h0104, 32'hcafef00d, 4'b1100);
		read_check("merge", 16'h0104);
		// A write miss to the same set must leave the cached word alone.
		write_word(16'h0e04, 32'h99aabbcc, 4'b1010);
		read_check("merge", 16'h0104);
		read_check("merge", 16'h0e04);
		wait_drained();
		check_eq("merge memory", shadow[16'h0104], u_mem.mem[16'h0104]);
		check_eq("merge memory", shadow[16'h0e04], u_mem.mem[16'h0e04]);
	endtask

	task automatic buffer_backpressure();
		logic [`DC_WORD_W-1:0] data;
		slow = 1'b1;
		for (int i = 0; i < 8; i++) begin
			data = $random(seed);
			write_word(16'h0108 + 16'(i), data, (i % 3 == 0) ? 4'b0101 : 4'b1111);
		end
		wait_drained();
		slow = 1'b0;
		for (int i = 0; i < 8; i++) begin
			check_eq("burst memory", shadow[16'h0108 + 16'(i)], u_mem.mem[16'h0108 + 16'(i)]);
			read_check("burst", 16'h0108 + 16'(i));
		end
	endtask

	task automatic conflict_disable();
		logic [`DC_WORD_W-1:0] data;
		int                    low;
		for (int r = 0; r < 3; r++) begin
			read_check("conflict", 16'h0125);
			read_check("conflict", 16'h0a35);
		end
		cenable = 1'b0;
		read_check("disable", 16'h0125);
		// Set 5 still holds this word, but with caching off it must miss.
		read_word(16'h0a35, data, low);
		check_eq("disable", shadow[16'h0a35], data);
		check_eq("disable miss", 32'(1), 32'(low != 0));
		write_word(16'h0f3c, 32'h0badf00d, 4'b1001);
		read_check("disable", 16'h0f3c);
		read_check("disable", 16'h0125);
		cenable = 1'b1;
		// Nothing was filled while caching was off, so set 5 still hits.
		read_word(16'h0a35, data, low);
		check_eq("enable", shadow[16'h0a35], data);
		check_eq("enable hit", 32'(0), 32'(low));
	endtask

	initial begin
		rst         = 1'b1;
		cenable     = 1'b1;
		slow        = 1'b0;
		m_req       = '0;
		seed        = 32'h93e6;
		checks      = 0;
		errors      = 0;
		writes_sent = 0;
		for (int a = 0; a < 2**`DC_ADDR_W; a++) begin
			shadow[a] = initial_word(`DC_ADDR_W'(a));
		end
		repeat (8) @(negedge clk);
		rst = 1'b0;
		reset_sweep();
		fill_then_hit(16'h0230);
		fill_then_hit(16'h0b37);
		fill_then_hit(16'h7ffa);
		write_merge();
		buffer_backpressure();
		conflict_disable();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_store.sv
hdl/dcache_mem_port.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verif/mem_model.sv
verif/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
TOP       := dcache_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST)) hdl/dcache_config.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
